// File: Makefile
# Verilator build and run for the beat staging testbench
VERILATOR ?= verilator
TOP       ?= tb_beats_drain
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/beats_defs.svh
// ----------------------------
// Beat staging sizes
// ----------------------------
`ifndef BEATS_DEFS_SVH
`define BEATS_DEFS_SVH

// Data path
`define BEAT_W            32      // Bits per W beat

// Buffer and virtual FIFO
`define FIFO_DEPTH        16      // Beats held
`define CNT_W             5       // log2(depth) + 1, pointer and count width

// Burst sizing
`define MAX_BURST         8       // Longest burst in beats
`define SIZE_W            8       // Burst length field

// Flag margins
`define ALMOST_WR_MARGIN  2
`define ALMOST_RD_MARGIN  2

`endif

// File: common/beats_pkg.sv
// ----------------------------
// Beat staging types
// ----------------------------
`include "beats_defs.svh"

package beats_pkg;

        // ----------------------------
        // Scalar types
        // ----------------------------
        typedef logic [`BEAT_W-1:0] beat_data_t;        // One beat of payload
        typedef logic [`CNT_W-1:0]  cnt_t;              // Pointers and occupancy

        // ----------------------------
        // Bus structs
        // ----------------------------
        // Outgoing W beat
        typedef struct packed {
                beat_data_t data;
                logic       last;                       // Final beat of burst
        } w_beat_t;

        // Burst request from the command side
        typedef struct packed {
                logic [`SIZE_W-1:0] len;                // Beats, 1..MAX_BURST
        } burst_cmd_t;

        // ----------------------------
        // Write engine FSM
        // ----------------------------
        typedef enum logic [1:0] {
                IDLE,                                   // Waiting for a command
                RESERVE,                                // Claiming beats from drain_ctrl
                STREAM                                  // Sending W beats
        } eng_state_t;

endpackage : beats_pkg

// File: drain/drain_ctrl.sv
// ----------------------------
// Drain reservation control
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module drain_ctrl
        import beats_pkg::*;
(
        input  logic               axi_aclk,
        input  logic               rst_n,
        input  logic               wr_valid,          // Beat accepted upstream
        input  logic               rd_valid,          // Engine asks for a burst
        input  logic [`SIZE_W-1:0] rd_size,           // Burst beats, held with rd_valid
        output logic               rd_ready,          // Enough unclaimed beats
        output cnt_t               data_available,    // Stored but unclaimed
        output logic               wr_almost_full,
        output logic               rd_almost_empty
);

        cnt_t wr_ptr;
        cnt_t rd_ptr;
        cnt_t wr_ptr_next;
        cnt_t rd_ptr_next;
        cnt_t count;
        logic full;
        logic empty;
        logic rd_grant;
        logic [`SIZE_W-1:0] count_ext;          // Count widened for size compare

        // ----------------------------
        // Pointer stepping
        // ----------------------------
        assign rd_grant    = rd_valid && rd_ready;
        assign wr_ptr_next = wr_ptr + cnt_t'(wr_valid);          // One beat per accept
        assign rd_ptr_next = rd_grant ? rd_ptr + rd_size[`CNT_W-1:0] : rd_ptr;

        always_ff @(posedge axi_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        wr_ptr <= wr_ptr_next;
                        rd_ptr <= rd_ptr_next;
                end
        end

        // Count and flags from the next pointers
        fifo_flags u_flags (
                .axi_aclk     (axi_aclk),
                .rst_n        (rst_n),
                .wr_ptr_next  (wr_ptr_next),
                .rd_ptr_next  (rd_ptr_next),
                .count        (count),
                .full         (full),
                .almost_full  (wr_almost_full),
                .empty        (empty),
                .almost_empty (rd_almost_empty)
        );

        // Grant only a whole burst, so streaming never underflows
        assign count_ext      = {{(`SIZE_W - `CNT_W){1'b0}}, count};
        assign rd_ready       = !empty && (count_ext >= rd_size);
        assign data_available = count;

        // ----------------------------
        // Checks
        // ----------------------------
        a_count_bound : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                count <= cnt_t'(`FIFO_DEPTH))
                else $error("drain_ctrl count above depth");

        a_size_nonzero : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                rd_valid |-> rd_size != '0)
                else $error("drain_ctrl zero size request");

        // Buffer backpressure must stop writes before the virtual FIFO fills past depth
        a_no_wr_full : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                full |-> !wr_valid)
                else $error("drain_ctrl write while full");

endmodule : drain_ctrl

// File: drain/fifo_flags.sv
// ----------------------------
// Occupancy count and flags
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module fifo_flags
        import beats_pkg::*;
(
        input  logic axi_aclk,
        input  logic rst_n,
        input  cnt_t wr_ptr_next,               // Write pointer after this edge
        input  cnt_t rd_ptr_next,               // Read pointer after this edge
        output cnt_t count,
        output logic full,
        output logic almost_full,
        output logic empty,
        output logic almost_empty
);

        // Thresholds in pointer width
        localparam cnt_t DEPTH_C   = cnt_t'(`FIFO_DEPTH);
        localparam cnt_t AFULL_C   = cnt_t'(`FIFO_DEPTH - `ALMOST_WR_MARGIN);
        localparam cnt_t AEMPTY_C  = cnt_t'(`ALMOST_RD_MARGIN);

        cnt_t diff_next;                        // Occupancy after this edge

        // Wrap bit makes the plain difference exact up to DEPTH
        assign diff_next = wr_ptr_next - rd_ptr_next;

        // ----------------------------
        // Registered status
        // ----------------------------
        always_ff @(posedge axi_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        count        <= '0;
                        full         <= 1'b0;
                        almost_full  <= 1'b0;
                        empty        <= 1'b1;     // Nothing stored out of reset
                        almost_empty <= 1'b1;
                end else begin
                        count        <= diff_next;
                        full         <= (diff_next == DEPTH_C);
                        almost_full  <= (diff_next >= AFULL_C);
                        empty        <= (diff_next == '0);
                        almost_empty <= (diff_next <= AEMPTY_C);
                end
        end

endmodule : fifo_flags

// File: dv/tb_beats_drain.sv
// ----------------------------
// Beat staging testbench
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module tb_beats_drain
        import beats_pkg::*;
();

        logic        axi_aclk;
        logic        rst_n;
        logic        in_valid;
        beat_data_t  in_data;
        logic        in_ready;
        logic        cmd_valid;
        burst_cmd_t  cmd;
        logic        cmd_ready;
        logic        w_valid;
        w_beat_t     w;
        logic        w_ready;
        cnt_t        data_available;
        logic        almost_full;
        logic        almost_empty;

        // Reference model state
        beat_data_t  ref_q[$];                  // Accepted beats in order
        int          len_q[$];                  // Accepted burst lengths
        int          lens[$];                   // Planned burst lengths
        int          pushed, reserved, cmds_acc, bursts, beat_idx;
        int          beats_sent, cmd_sent;      // Driver side counts
        int          errors, checks, n, total, target, cmd_target;
        logic        stall_prev;
        w_beat_t     w_prev;
        w_beat_t     exp_w;
        logic [31:0] lfsr = 32'h520f;

        beats_drain_top dut0 (.*);

        initial begin
                axi_aclk = 1'b0;
                forever #50 axi_aclk = ~axi_aclk;       // 100 ns period
        end

        // Fibonacci LFSR with taps 32 22 2 1
        function automatic logic [31:0] rand_bits(input int nbits);
                logic [31:0] r;
                r = '0;
                for (int b = 0; b < nbits; b++) begin
                        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                        r    = {r[30:0], lfsr[0]};      // One step per bit
                end
                return r;
        endfunction

        // Expected W beat from the queue head
        function automatic w_beat_t expect_beat(input beat_data_t data, input int idx,
                                                input int len);
                w_beat_t b;
                b.data = data;
                b.last = (idx == len);                  // Final beat closes the burst
                return b;
        endfunction

        task automatic check_eq(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Fail %0t %s expected %0h got %0h", $time, name, exp, got);
                end
        endtask

        task automatic stop_on_timeout(input string what);
                errors++;
                $display("Timeout waiting for %s with %0d errors", what, errors);
                $display("CHECKS FAILED");
                $finish;
        endtask

        // Ready mode selects low (0) high (1) or random (2)
        task automatic drive_cycle(input int beat_limit, input int cmd_limit,
                                   input int ready_mode, input bit gaps);
                if (pushed == beats_sent) begin         // Previous beat taken
                        in_valid = 1'b0;
                        if (beats_sent < beat_limit && (!gaps || rand_bits(1))) begin
                                in_valid = 1'b1;
                                in_data  = rand_bits(32);
                                beats_sent++;
                        end
                end
                if (cmds_acc == cmd_sent) begin
                        cmd_valid = 1'b0;
                        if (cmd_sent < cmd_limit && (!gaps || rand_bits(1))) begin
                                cmd_valid = 1'b1;
                                cmd.len   = `SIZE_W'(lens[cmd_sent]);
                                cmd_sent++;
                        end
                end
                w_ready = (ready_mode == 2) ? (rand_bits(1) != 0) : (ready_mode == 1);
        endtask

        task automatic run_until(input int beat_limit, input int cmd_limit,
                                 input int ready_mode, input bit gaps, input string what);
                int k;
                for (k = 0; k < 5000; k++) begin
                        @(negedge axi_aclk);
                        drive_cycle(beat_limit, cmd_limit, ready_mode, gaps);
                        if (pushed == beat_limit && bursts == cmd_limit)
                                break;
                end
                if (k == 5000)
                        stop_on_timeout(what);
        endtask

        task automatic plan_bursts(input int count, output int beats);
                int len;
                beats = 0;
                repeat (count) begin
                        len = int'(rand_bits(3)) + 1;   // 1 to MAX_BURST
                        lens.push_back(len);
                        beats += len;
                end
        endtask

        // ----------------------------
        // Transfer monitor and compare
        // ----------------------------
        always @(posedge axi_aclk) begin
                if (rst_n) begin
                        if (stall_prev && !w_valid) begin
                                errors++;
                                $display("Fail %0t w_valid expected 1 got 0", $time);
                        end else if (stall_prev && w !== w_prev) begin
                                errors++;
                                $display("Fail %0t w expected %h got %h", $time, w_prev, w);
                        end
                        if (w_valid && w_ready) begin
                                checks++;
                                if (ref_q.size() == 0 || len_q.size() == 0) begin
                                        errors++;
                                        $display("W beat at %0t with no stored beat", $time);
                                end else begin
                                        beat_idx++;
                                        exp_w = expect_beat(ref_q.pop_front(), beat_idx,
                                                            len_q[0]);
                                        if (w !== exp_w) begin
                                                errors++;
                                                $display("Fail %0t w expected %h got %h",
                                                         $time, exp_w, w);
                                        end
                                        if (data_available !== cnt_t'(pushed - reserved)) begin
                                                errors++;
                                                $display("Fail %0t data_available expected %0d got %0d",
                                                         $time, pushed - reserved, data_available);
                                        end
                                        if (exp_w.last) begin   // Burst closed
                                                void'(len_q.pop_front());
                                                beat_idx = 0;
                                                bursts++;
                                        end
                                end
                        end
                        if (in_valid && in_ready) begin
                                ref_q.push_back(in_data);
                                pushed++;
                        end
                        if (cmd_valid && cmd_ready) begin
                                len_q.push_back(int'(cmd.len));
                                reserved += int'(cmd.len);  // Claimed before streaming
                                cmds_acc++;
                        end
                        stall_prev = w_valid && !w_ready;
                        w_prev     = w;
                end
        end

        initial begin
                rst_n      = 1'b0;
                in_valid   = 1'b0;
                in_data    = '0;
                cmd_valid  = 1'b0;
                cmd        = '0;
                w_ready    = 1'b0;
                stall_prev = 1'b0;
                w_prev     = '0;
                repeat (3) @(negedge axi_aclk);
                rst_n = 1'b1;

                // Reset values
                check_eq("w_valid", w_valid, 0);
                check_eq("rd_valid", dut0.rd_valid, 0);
                check_eq("cmd_ready", cmd_ready, 1);
                check_eq("in_ready", in_ready, 1);
                check_eq("data_available", data_available, 0);
                check_eq("almost_empty", almost_empty, 1);
                check_eq("almost_full", almost_full, 0);

                // Four beats first, then one burst of 4
                lens.push_back(4);
                run_until(beats_sent + 4, cmd_sent, 1, 0, "four beats");
                run_until(beats_sent, cmd_sent + 1, 1, 0, "burst of four");

                // ----------------------------
                // Burst of 6 over 3 stored beats
                // ----------------------------
                lens.push_back(6);
                run_until(beats_sent + 3, cmd_sent, 1, 0, "three stored beats");
                target     = beats_sent + 3;
                cmd_target = cmd_sent + 1;
                @(negedge axi_aclk);
                drive_cycle(beats_sent, cmd_target, 0, 0);      // Command alone
                for (n = 0; n < 200 && pushed < target; n++) begin
                        @(negedge axi_aclk);
                        check_eq("w_valid", w_valid, 0);
                        drive_cycle(target, cmd_target, 0, 1);
                end
                if (pushed < target)
                        stop_on_timeout("last three beats");
                check_eq("data_available", data_available, 6);
                @(negedge axi_aclk);                            // Grant edge passed
                check_eq("w_valid", w_valid, 1);
                check_eq("data_available", data_available, 0);
                run_until(target, cmd_target, 1, 0, "burst of six");

                // Random w_ready bursts
                plan_bursts(5, total);
                run_until(beats_sent + total, cmd_sent + 5, 2, 1, "random ready bursts");

                // Fill the buffer with no commands
                target = beats_sent + 16;
                for (n = 0; n < 100 && pushed < target; n++) begin
                        @(negedge axi_aclk);
                        check_eq("data_available", data_available, pushed - reserved);
                        check_eq("almost_full", almost_full, (pushed - reserved) >= 14);
                        drive_cycle(target, cmd_sent, 1, 0);
                end
                if (pushed < target)
                        stop_on_timeout("sixteen beats");
                check_eq("in_ready", in_ready, 0);
                check_eq("data_available", data_available, 16);
                lens.push_back(8);
                lens.push_back(8);
                run_until(beats_sent, cmd_sent + 2, 1, 0, "drain of full buffer");

                // Random mix of 40 bursts
                plan_bursts(40, total);
                run_until(beats_sent + total, cmd_sent + 40, 2, 1, "random mix");

                check_eq("data_available", data_available, 0);
                check_eq("almost_empty", almost_empty, 1);
                check_eq("cmd_ready", cmd_ready, 1);
                $display("Checks run %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule : tb_beats_drain

// File: hdl/beat_buffer.sv
// ----------------------------
// Beat storage FIFO
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module beat_buffer
        import beats_pkg::*;
#(
        parameter int DEPTH = `FIFO_DEPTH
) (
        input  logic       axi_aclk,
        input  logic       rst_n,
        input  logic       push,                // Accepted input beat
        input  beat_data_t push_data,
        input  logic       pop,                 // W beat transferred
        output beat_data_t head,                // Oldest beat, fall-through
        output logic       not_full
);

        localparam int AW = $clog2(DEPTH);

        beat_data_t    mem [DEPTH];             // Payload only, no reset
        logic [AW:0]   wr_ptr;                  // MSB is the wrap bit
        logic [AW:0]   rd_ptr;
        logic          empty;

        // Same slot, wrap bits differ means full
        assign not_full = !((wr_ptr[AW] != rd_ptr[AW]) &&
                            (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));
        assign empty    = (wr_ptr == rd_ptr);
        assign head     = mem[rd_ptr[AW-1:0]];

        always_ff @(posedge axi_aclk) begin
                if (push)
                        mem[wr_ptr[AW-1:0]] <= push_data;
        end

        // ----------------------------
        // Pointers
        // ----------------------------
        always_ff @(posedge axi_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (pop)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        a_no_push_full : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                push |-> not_full) else $error("beat_buffer push when full");

        a_no_pop_empty : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                pop |-> !empty) else $error("beat_buffer pop when empty");

endmodule : beat_buffer

// File: hdl/beats_drain_top.sv
// ----------------------------
// Beat staging top
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module beats_drain_top
        import beats_pkg::*;
(
        input  logic       axi_aclk,
        input  logic       rst_n,
        // Producer beats
        input  logic       in_valid,
        input  beat_data_t in_data,
        output logic       in_ready,
        // Burst commands
        input  logic       cmd_valid,
        input  burst_cmd_t cmd,
        output logic       cmd_ready,
        // W channel
        output logic       w_valid,
        output w_beat_t    w,
        input  logic       w_ready,
        // Status
        output cnt_t       data_available,
        output logic       almost_full,
        output logic       almost_empty
);

        logic               in_accept;          // Beat taken this edge
        logic               rd_valid;
        logic [`SIZE_W-1:0] rd_size;
        logic               rd_ready;
        beat_data_t         head;
        logic               pop;

        assign in_accept = in_valid && in_ready;

        // Unclaimed beat tracking
        drain_ctrl u_drain (
                .axi_aclk        (axi_aclk),
                .rst_n           (rst_n),
                .wr_valid        (in_accept),
                .rd_valid        (rd_valid),
                .rd_size         (rd_size),
                .rd_ready        (rd_ready),
                .data_available  (data_available),
                .wr_almost_full  (almost_full),
                .rd_almost_empty (almost_empty)
        );

        beat_buffer u_buf (
                .axi_aclk  (axi_aclk),
                .rst_n     (rst_n),
                .push      (in_accept),
                .push_data (in_data),
                .pop       (pop),
                .head      (head),
                .not_full  (in_ready)
        );

        write_engine u_eng (
                .axi_aclk  (axi_aclk),
                .rst_n     (rst_n),
                .cmd_valid (cmd_valid),
                .cmd       (cmd),
                .cmd_ready (cmd_ready),
                .rd_valid  (rd_valid),
                .rd_size   (rd_size),
                .rd_ready  (rd_ready),
                .head      (head),
                .pop       (pop),
                .w_valid   (w_valid),
                .w         (w),
                .w_ready   (w_ready)
        );

endmodule : beats_drain_top

// File: hdl/write_engine.sv
// ----------------------------
// W burst sequencer
// ----------------------------
`timescale 1ns/1ps

`include "beats_defs.svh"

module write_engine
        import beats_pkg::*;
(
        input  logic               axi_aclk,
        input  logic               rst_n,
        input  logic               cmd_valid,
        input  burst_cmd_t         cmd,
        output logic               cmd_ready,
        output logic               rd_valid,          // Reservation request
        output logic [`SIZE_W-1:0] rd_size,
        input  logic               rd_ready,
        input  beat_data_t         head,              // Buffer head beat
        output logic               pop,
        output logic               w_valid,
        output w_beat_t            w,
        input  logic               w_ready
);

        eng_state_t         state;
        eng_state_t         state_next;
        logic [`SIZE_W-1:0] len;                // Latched burst length
        logic [`SIZE_W-1:0] beat_cnt;           // 1-based beat in burst
        logic               last_beat;

        // ----------------------------
        // Handshakes
        // ----------------------------
        assign cmd_ready = (state == IDLE);
        assign rd_valid  = (state == RESERVE);
        assign rd_size   = len;                 // Stable through RESERVE
        assign w_valid   = (state == STREAM);
        assign last_beat = (beat_cnt == len);
        assign w.data    = head;
        assign w.last    = last_beat;
        assign pop       = w_valid && w_ready;  // No pop while stalled

        always_comb begin
                state_next = state;
                case (state)
                        IDLE:    if (cmd_valid) state_next = RESERVE;
                        RESERVE: if (rd_ready) state_next = STREAM;  // Whole burst claimed
                        STREAM:  if (pop && last_beat) state_next = IDLE;
                        default: state_next = IDLE;
                endcase
        end

        always_ff @(posedge axi_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= IDLE;
                        len      <= '0;
                        beat_cnt <= '0;
                end else begin
                        state <= state_next;
                        if (cmd_valid && cmd_ready)
                                len <= cmd.len;
                        if (state == RESERVE)
                                beat_cnt <= `SIZE_W'(1);      // First beat of the burst
                        else if (pop)
                                beat_cnt <= beat_cnt + 1'b1;
                end
        end

        // ----------------------------
        // Checks
        // ----------------------------
        a_cmd_len : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                (cmd_valid && cmd_ready) |-> (cmd.len >= 1 && cmd.len <= `MAX_BURST))
                else $error("write_engine burst length out of range");

        // Stalled beat holds until taken, relies on buffer head staying put
        a_w_hold : assert property (@(posedge axi_aclk) disable iff (!rst_n)
                (w_valid && !w_ready) |=> (w_valid && $stable(w)))
                else $error("write_engine W changed under stall");

endmodule : write_engine

// File: list.f
+incdir+common
common/beats_pkg.sv
drain/fifo_flags.sv
drain/drain_ctrl.sv
hdl/beat_buffer.sv
hdl/write_engine.sv
hdl/beats_drain_top.sv
dv/tb_beats_drain.sv
